/* common/dab_pkg.sv */
`default_nettype none

package dab_pkg;

  ////////////////////
  // widths
  localparam int volt_w = 12;           // vdc1, vdc2 unsigned
  localparam int iref_w = 12;           // iref signed
  localparam int disc_w = 28;           // signed discriminant
  localparam int rad_w  = 24;           // sqrt radicand
  localparam int root_w = 12;
  localparam int out_w  = 9;            // tau1, tau2, phi
  localparam int step_w = 5;

  ////////////////////
  // constants
  localparam int k_pow       = 4;       // load coefficient in disc
  localparam int angle_shift = 4;       // voltage difference to angle units

  localparam logic signed [out_w-1:0] tau_full = 9'sd255;
  localparam logic signed [out_w-1:0] tau1_rst = 9'sd255;
  localparam logic signed [out_w-1:0] tau2_rst = 9'sd147;
  localparam logic signed [out_w-1:0] phi_rst  = -9'sd9;

  // phase ends, cycle 1 is the first one after sync
  localparam logic [step_w-1:0] step_sample_end = 5'd1;
  localparam logic [step_w-1:0] step_square_end = 5'd3;
  localparam logic [step_w-1:0] step_root_end   = 5'd15;
  localparam logic [step_w-1:0] step_angle_end  = 5'd16;

  ////////////////////
  // types
  typedef enum logic [2:0] {
    st_idle,
    st_sample,
    st_square,
    st_root,
    st_angle
  } calc_state_t;

  typedef enum logic [1:0] {
    mode_tri  = 2'd0,
    mode_trap = 2'd1,                   // reserved
    mode_sps  = 2'd2,
    mode_none = 2'd3
  } dab_mode_t;

  typedef struct packed {
    logic [volt_w-1:0]        vdc1;
    logic [volt_w-1:0]        vdc2;
    logic signed [iref_w-1:0] iref;
  } calc_in_t;

  typedef struct packed {
    logic sample_end;
    logic square_end;
    logic root_end;
    logic angle_end;
  } step_t;

  typedef struct packed {
    logic signed [out_w-1:0] tau1;
    logic signed [out_w-1:0] tau2;
    logic signed [out_w-1:0] phi;
    dab_mode_t               modo;
  } mod_out_t;

endpackage

`default_nettype wire

/* sequencer/step_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module step_counter (
  input  logic           clk,
  input  logic           rst,
  input  logic           ce,
  input  logic           step_clr,
  output dab_pkg::step_t steps
);
  import dab_pkg::*;

  logic [step_w-1:0] cnt_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (ce) begin
      if (step_clr) begin
        cnt_q <= step_w'(1);                  // next cycle is the first counted one
      end else if (cnt_q != step_angle_end) begin
        cnt_q <= cnt_q + 1'b1;                // stops at the last phase end
      end
    end
  end

  always_comb begin
    steps.sample_end = (cnt_q == step_sample_end);
    steps.square_end = (cnt_q == step_square_end);
    steps.root_end   = (cnt_q == step_root_end);
    steps.angle_end  = (cnt_q == step_angle_end);
  end

endmodule

`default_nettype wire

/* sequencer/calc_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module calc_fsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ce,
  input  logic                 sync,
  input  dab_pkg::step_t       steps,
  output dab_pkg::calc_state_t calc_state,
  output logic                 step_clr,
  output logic                 calc_done
);
  import dab_pkg::*;

  calc_state_t state_q;
  calc_state_t state_d;
  logic        done_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (sync) state_d = st_sample;        // sync mid-run never reaches here
      end
      st_sample: begin
        if (steps.sample_end) state_d = st_square;
      end
      st_square: begin
        if (steps.square_end) state_d = st_root;
      end
      st_root: begin
        if (steps.root_end) state_d = st_angle;
      end
      st_angle: begin
        if (steps.angle_end) state_d = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= st_idle;
      done_q  <= 1'b0;
    end else if (ce) begin
      state_q <= state_d;
      done_q  <= (state_q == st_root) && steps.root_end;  // high for the st_angle cycle
    end
  end

  assign calc_state = state_q;
  assign step_clr   = (state_q == st_idle);   // counter restarts with the run
  assign calc_done  = done_q;

  // the done pulse is registered from st_root, so it must line up with st_angle
  done_in_angle: assert property (
    @(posedge clk) disable iff (rst) calc_done |-> (calc_state == st_angle)
  );

endmodule

`default_nettype wire

/* datapath/discriminant_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module discriminant_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ce,
  input  dab_pkg::calc_state_t       calc_state,
  input  dab_pkg::calc_in_t          meas,
  output logic [dab_pkg::rad_w-1:0]  radicand,
  output logic                       disc_neg,
  output logic [dab_pkg::volt_w-1:0] vdc2_s,
  output logic                       iref_neg
);
  import dab_pkg::*;

  logic [iref_w-1:0]        iref_mag;
  logic [rad_w-1:0]         sq_d;
  logic [disc_w-1:0]        load_d;
  logic [rad_w-1:0]         sq_q;       // vdc2^2
  logic [disc_w-1:0]        load_q;     // k_pow * |iref| * vdc1
  logic signed [disc_w-1:0] disc;

  // -2048 maps onto 12'h800, which is still the right magnitude
  assign iref_mag = meas.iref[iref_w-1] ? iref_w'(-meas.iref) : iref_w'(meas.iref);

  assign sq_d   = rad_w'(meas.vdc2) * rad_w'(meas.vdc2);
  assign load_d = disc_w'(k_pow) * disc_w'(iref_mag) * disc_w'(meas.vdc1);

  assign disc = disc_w'(sq_q) - load_q;

  ////////////////////
  // sample stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vdc2_s   <= '0;
      iref_neg <= 1'b0;
      sq_q     <= '0;
      load_q   <= '0;
    end else if (ce && calc_state == st_sample) begin
      vdc2_s   <= meas.vdc2;
      iref_neg <= meas.iref[iref_w-1];
      sq_q     <= sq_d;
      load_q   <= load_d;
    end
  end

  ////////////////////
  // difference stage, ready before the sqrt load
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      disc_neg <= 1'b0;
      radicand <= '0;
    end else if (ce && calc_state == st_square) begin
      disc_neg <= disc[disc_w-1];
      radicand <= disc[rad_w-1:0];            // disc <= vdc2^2 < 2^24 when positive
    end
  end

endmodule

`default_nettype wire

/* datapath/isqrt_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module isqrt_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ce,
  input  dab_pkg::calc_state_t       calc_state,
  input  logic                       square_end,
  input  logic [dab_pkg::rad_w-1:0]  radicand,
  output logic [dab_pkg::root_w-1:0] root
);
  import dab_pkg::*;

  logic [rad_w-1:0] rem_q;              // remainder
  logic [rad_w-1:0] res_q;              // partial root, scaled by the trial bit
  logic [rad_w-1:0] bit_q;              // trial bit, a power of four
  logic [rad_w-1:0] trial;
  logic             fits;

  assign trial = res_q + bit_q;
  assign fits  = (rem_q >= trial);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rem_q <= '0;
      res_q <= '0;
      bit_q <= '0;
    end else if (ce) begin
      if (calc_state == st_square && square_end) begin
        rem_q <= radicand;
        res_q <= '0;
        bit_q <= {2'b01, {(rad_w-2){1'b0}}};  // 4^11, top of a 24 bit radicand
      end else if (calc_state == st_root && bit_q != '0) begin
        if (fits) begin
          rem_q <= rem_q - trial;
          res_q <= (res_q >> 1) + bit_q;      // root bit is one
        end else begin
          res_q <= res_q >> 1;                // root bit is zero
        end
        bit_q <= bit_q >> 2;                  // twelve steps to zero
      end
    end
  end

  assign root = res_q[root_w-1:0];

  // once the trial bit has run out the scaled root is down to 12 bits
  root_fits: assert property (
    @(posedge clk) disable iff (rst)
      (bit_q == '0) |-> (res_q[rad_w-1:root_w] == '0)
  );

endmodule

`default_nettype wire

/* design/mode_select.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_select (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ce,
  input  logic                       trigger,
  input  logic                       calc_done,
  input  logic                       disc_neg,
  input  logic [dab_pkg::root_w-1:0] root,
  input  logic [dab_pkg::volt_w-1:0] vdc2_s,
  input  logic                       iref_neg,
  output dab_pkg::mod_out_t          pwm_cmd
);
  import dab_pkg::*;

  logic [volt_w-1:0]             diff;
  logic [volt_w-angle_shift-1:0] mag;
  logic signed [out_w-1:0]       angle_d;
  logic signed [out_w-1:0]       angle_q;
  logic                          res_valid_q;
  logic                          feasible_q;
  logic                          trig_q;
  logic                          trig_qq;
  logic                          trig_edge;

  ////////////////////
  // angle from the finished run
  assign diff    = vdc2_s - root;             // root <= vdc2 whenever disc >= 0
  assign mag     = diff[volt_w-1:angle_shift];
  assign angle_d = iref_neg ? -$signed({1'b0, mag}) : $signed({1'b0, mag});

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_valid_q <= 1'b0;
      feasible_q  <= 1'b0;
    end else if (ce && calc_done) begin
      res_valid_q <= 1'b1;
      feasible_q  <= ~disc_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (ce && calc_done) begin
      angle_q <= angle_d;
    end
  end

  ////////////////////
  // trigger edge and output update
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      trig_q  <= 1'b0;
      trig_qq <= 1'b0;
    end else if (ce) begin
      trig_q  <= trigger;
      trig_qq <= trig_q;
    end
  end

  assign trig_edge = trig_q & ~trig_qq;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pwm_cmd.tau1 <= tau1_rst;
      pwm_cmd.tau2 <= tau2_rst;
      pwm_cmd.phi  <= phi_rst;
      pwm_cmd.modo <= mode_tri;
    end else if (ce && trig_edge) begin
      if (res_valid_q && feasible_q) begin
        pwm_cmd.tau1 <= tau_full;
        pwm_cmd.tau2 <= tau_full;
        pwm_cmd.phi  <= angle_q;
        pwm_cmd.modo <= mode_sps;
      end else begin
        pwm_cmd.modo <= mode_none;            // widths and angle hold
      end
    end
  end

  // only tri (reset), sps and none are ever driven
  no_trap_mode: assert property (
    @(posedge clk) disable iff (rst) pwm_cmd.modo != mode_trap
  );

endmodule

`default_nettype wire

/* design/dab_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dab_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              ce,
  input  logic              sync,
  input  logic              trigger,
  input  dab_pkg::calc_in_t meas,
  output dab_pkg::mod_out_t pwm_cmd
);
  import dab_pkg::*;

  calc_state_t       calc_state;
  step_t             steps;
  logic              step_clr;
  logic              calc_done;
  logic [rad_w-1:0]  radicand;
  logic              disc_neg;
  logic [volt_w-1:0] vdc2_s;
  logic              iref_neg;
  logic [root_w-1:0] root;

  ////////////////////
  // sequencing
  calc_fsm calc_fsm_i (
    .clk        (clk),
    .rst        (rst),
    .ce         (ce),
    .sync       (sync),
    .steps      (steps),
    .calc_state (calc_state),
    .step_clr   (step_clr),
    .calc_done  (calc_done)
  );

  step_counter step_counter_i (
    .clk      (clk),
    .rst      (rst),
    .ce       (ce),
    .step_clr (step_clr),
    .steps    (steps)
  );

  ////////////////////
  // datapath
  discriminant_unit discriminant_unit_i (
    .clk        (clk),
    .rst        (rst),
    .ce         (ce),
    .calc_state (calc_state),
    .meas       (meas),
    .radicand   (radicand),
    .disc_neg   (disc_neg),
    .vdc2_s     (vdc2_s),
    .iref_neg   (iref_neg)
  );

  isqrt_unit isqrt_unit_i (
    .clk        (clk),
    .rst        (rst),
    .ce         (ce),
    .calc_state (calc_state),
    .square_end (steps.square_end),
    .radicand   (radicand),
    .root       (root)
  );

  mode_select mode_select_i (
    .clk       (clk),
    .rst       (rst),
    .ce        (ce),
    .trigger   (trigger),
    .calc_done (calc_done),
    .disc_neg  (disc_neg),
    .root      (root),
    .vdc2_s    (vdc2_s),
    .iref_neg  (iref_neg),
    .pwm_cmd   (pwm_cmd)
  );

endmodule

`default_nettype wire

/* test/dab_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dab_ctrl_tb;
  import dab_pkg::*;

  localparam int n_fixed  = 10;
  localparam int n_rand   = 8;
  localparam int n_rows   = n_fixed + n_rand;
  localparam int max_cyc  = n_rows * 40 + 100;

  typedef struct packed {
    logic [volt_w-1:0]        vdc1;
    logic [volt_w-1:0]        vdc2;
    logic signed [iref_w-1:0] iref;
    logic                     ce_low;     // sync and trigger while frozen
    dab_mode_t                modo;
    logic signed [out_w-1:0]  tau1;
    logic signed [out_w-1:0]  tau2;
    logic signed [out_w-1:0]  phi;
  } row_t;

  logic     clk;
  logic     rst;
  logic     ce;
  logic     sync;
  logic     trigger;
  calc_in_t meas;
  mod_out_t pwm_cmd;

  row_t        rows [n_rows];
  int          errors;
  int          checks;
  logic [15:0] lfsr;

  dab_ctrl dab_ctrl_i (
    .clk     (clk),
    .rst     (rst),
    .ce      (ce),
    .sync    (sync),
    .trigger (trigger),
    .meas    (meas),
    .pwm_cmd (pwm_cmd)
  );

  always #20 clk = ~clk;                  // 40 ns period

  ////////////////////
  // reference model
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[15]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic longint floor_sqrt(input longint x);
    longint r;
    r = 0;
    while ((r + 1) * (r + 1) <= x) begin
      r++;
    end
    return r;
  endfunction

  function automatic row_t make_row(input int vdc1, input int vdc2, input int iref,
                                    input int ce_low, input dab_mode_t modo,
                                    input int tau1, input int tau2, input int phi);
    row_t r;
    r.vdc1   = volt_w'(vdc1);
    r.vdc2   = volt_w'(vdc2);
    r.iref   = iref_w'(iref);
    r.ce_low = (ce_low != 0);
    r.modo   = modo;
    r.tau1   = out_w'(tau1);
    r.tau2   = out_w'(tau2);
    r.phi    = out_w'(phi);
    return r;
  endfunction

  // infeasible rows keep the widths and angle of the row before
  function automatic row_t expect_row(input row_t cur, input row_t prev);
    row_t   e;
    longint ia;
    longint disc;
    longint mag;
    e    = cur;
    ia   = cur.iref[iref_w-1] ? -longint'(cur.iref) : longint'(cur.iref);
    disc = longint'(cur.vdc2) * longint'(cur.vdc2) - k_pow * ia * longint'(cur.vdc1);
    if (disc >= 0) begin
      mag    = (longint'(cur.vdc2) - floor_sqrt(disc)) >> angle_shift;
      e.modo = mode_sps;
      e.tau1 = out_w'(255);
      e.tau2 = out_w'(255);
      e.phi  = cur.iref[iref_w-1] ? out_w'(-mag) : out_w'(mag);
    end else begin
      e.modo = mode_none;
      e.tau1 = prev.tau1;
      e.tau2 = prev.tau2;
      e.phi  = prev.phi;
    end
    return e;
  endfunction

  task automatic build_table();
    row_t        raw;
    logic [15:0] bits;
    rows[0] = make_row(1234, 2345,  -321, 1, mode_tri,  255, 147,   -9);  // frozen
    rows[1] = make_row(1000, 1000,   100, 0, mode_sps,  255, 255,   14);
    rows[2] = make_row(2000, 3000,     0, 0, mode_sps,  255, 255,    0);  // iref zero
    rows[3] = make_row(1000, 1000,  -100, 0, mode_sps,  255, 255,  -14);
    rows[4] = make_row(4000,  500,   500, 0, mode_none, 255, 255,  -14);  // disc < 0
    rows[5] = make_row( 100, 4095,  2047, 0, mode_sps,  255, 255,    6);
    rows[6] = make_row( 100, 4095, -2048, 0, mode_sps,  255, 255,   -6);
    rows[7] = make_row( 100,  400,   400, 0, mode_sps,  255, 255,   25);  // disc == 0
    rows[8] = make_row(4000, 4000, -1000, 0, mode_sps,  255, 255, -250);
    rows[9] = make_row( 100,  400,   401, 0, mode_none, 255, 255, -250);
    for (int i = n_fixed; i < n_rows; i++) begin
      raw = '0;
      take_bits(12, bits);
      raw.vdc1 = bits[11:0];
      take_bits(12, bits);
      raw.vdc2 = bits[11:0];
      take_bits(9, bits);
      raw.iref = iref_w'($signed(bits[8:0]));  // small iref keeps many rows feasible
      rows[i] = expect_row(raw, rows[i-1]);
    end
  endtask

  ////////////////////
  // stimulus and checks
  task automatic apply_row(input row_t r);
    @(negedge clk);
    meas.vdc1 = r.vdc1;
    meas.vdc2 = r.vdc2;
    meas.iref = r.iref;
    if (r.ce_low) begin
      ce   = 1'b0;
      sync = 1'b1;
      @(negedge clk);
      sync    = 1'b0;
      trigger = 1'b1;
      @(negedge clk);
      trigger = 1'b0;
      @(negedge clk);
      ce = 1'b1;
      repeat (3) @(negedge clk);
    end else begin
      sync = 1'b1;
      @(negedge clk);
      sync = 1'b0;
      @(negedge clk);
      meas = calc_in_t'(~meas);           // sample edge has passed
      repeat (22) @(negedge clk);
      trigger = 1'b1;
      @(negedge clk);
      trigger = 1'b0;
      repeat (2) @(negedge clk);
    end
  endtask

  task automatic check_field(input string label, input string name,
                             input int got, input int want);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("Error at %0t: %s %s is %0d, expected %0d", $time, label, name, got, want);
    end
  endtask

  task automatic compare_outputs(input row_t e, input string label);
    check_field(label, "modo", int'(pwm_cmd.modo), int'(e.modo));
    check_field(label, "tau1", int'(pwm_cmd.tau1), int'(e.tau1));
    check_field(label, "tau2", int'(pwm_cmd.tau2), int'(e.tau2));
    check_field(label, "phi",  int'(pwm_cmd.phi),  int'(e.phi));
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    ce      = 1'b1;
    sync    = 1'b0;
    trigger = 1'b0;
    meas    = '0;
    errors  = 0;
    checks  = 0;
    lfsr    = 16'd49254;
    build_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    compare_outputs(make_row(0, 0, 0, 0, mode_tri, 255, 147, -9), "reset");
    for (int i = 0; i < n_rows; i++) begin
      apply_row(rows[i]);
      compare_outputs(rows[i], $sformatf("row %0d", i));
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (max_cyc) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", max_cyc);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
common/dab_pkg.sv
sequencer/step_counter.sv
sequencer/calc_fsm.sv
datapath/discriminant_unit.sv
datapath/isqrt_unit.sv
design/mode_select.sv
design/dab_ctrl.sv
test/dab_ctrl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module dab_ctrl_tb -f verilog.f
out=$(./obj_dir/Vdab_ctrl_tb)
echo "$out"
if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
